//--- hw/pe_cfg_pkg.sv
package pe_cfg_pkg;

  // 4-way groups, four levels deep
  localparam int GROUP_W = 4;
  localparam int LEVELS  = 4;
  localparam int REQ_W   = GROUP_W ** LEVELS;
  localparam int IDX_W   = $clog2(REQ_W);

  // groups per tree level, leaf level first
  localparam int GROUPS_L0 = REQ_W / GROUP_W;
  localparam int GROUPS_L1 = GROUPS_L0 / GROUP_W;
  localparam int GROUPS_L2 = GROUPS_L1 / GROUP_W;
  localparam int GROUPS_L3 = GROUPS_L2 / GROUP_W;

  // request bus split into words
  localparam int WORD_W  = 32;
  localparam int N_WORDS = REQ_W / WORD_W;

endpackage

//--- hw/pe_types_pkg.sv
package pe_types_pkg;

  // raw request lines, bit n is request n
  typedef logic [pe_cfg_pkg::N_WORDS-1:0][pe_cfg_pkg::WORD_W-1:0] req_vec_t;

  // one-hot winner, same layout as the request vector
  typedef logic [pe_cfg_pkg::N_WORDS-1:0][pe_cfg_pkg::WORD_W-1:0] grant_vec_t;

  // encoder output
  typedef struct packed {
    logic                         valid;
    logic [pe_cfg_pkg::IDX_W-1:0] index;
  } pe_result_t;

  // valid low always comes with index zero
  localparam pe_result_t RESULT_IDLE = '{valid: 1'b0, index: '0};

endpackage

//--- hw/pe_req_capture.sv
module pe_req_capture (
  input  logic                  clk,
  input  logic                  reset,
  input  pe_types_pkg::req_vec_t request,
  output pe_types_pkg::req_vec_t captured
);

  pe_types_pkg::req_vec_t req_q;

  // launch register for the tree path
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else begin
      req_q <= request;
    end
  end

  assign captured = req_q;

endmodule

//--- hw/pe_group_level.sv
module pe_group_level #(
  parameter int N_GROUPS = 1
) (
  input  logic [N_GROUPS*pe_cfg_pkg::GROUP_W-1:0] req,
  output logic [N_GROUPS*pe_cfg_pkg::GROUP_W-1:0] grant,
  output logic [N_GROUPS-1:0]                     group_any
);

  for (genvar g = 0; g < N_GROUPS; g++) begin : g_group
    logic [pe_cfg_pkg::GROUP_W-1:0] grp_req;
    logic [pe_cfg_pkg::GROUP_W-1:0] grp_grant;

    assign grp_req = req[g*pe_cfg_pkg::GROUP_W +: pe_cfg_pkg::GROUP_W];

    // highest-numbered set input wins
    always_comb begin
      grp_grant = '0;
      for (int b = 0; b < pe_cfg_pkg::GROUP_W; b++) begin
        if (grp_req[b]) begin
          grp_grant    = '0;
          grp_grant[b] = 1'b1;
        end
      end
    end

    assign grant[g*pe_cfg_pkg::GROUP_W +: pe_cfg_pkg::GROUP_W] = grp_grant;

    // feeds the next level up
    assign group_any[g] = |grp_req;
  end

endmodule

//--- hw/pe_priority_tree.sv
module pe_priority_tree (
  input  pe_types_pkg::req_vec_t   req,
  output pe_types_pkg::grant_vec_t grant,
  output logic                     any_set
);

  // raw per-level grants, one-hot inside each group only
  logic [pe_cfg_pkg::REQ_W-1:0]     grant_l0;
  logic [pe_cfg_pkg::GROUPS_L0-1:0] grant_l1;
  logic [pe_cfg_pkg::GROUPS_L1-1:0] grant_l2;
  logic [pe_cfg_pkg::GROUPS_L2-1:0] grant_l3;

  // group OR outputs, each one the next level's requests
  logic [pe_cfg_pkg::GROUPS_L0-1:0] any_l0;
  logic [pe_cfg_pkg::GROUPS_L1-1:0] any_l1;
  logic [pe_cfg_pkg::GROUPS_L2-1:0] any_l2;
  logic [pe_cfg_pkg::GROUPS_L3-1:0] any_l3;

  // grants after masking by the parent group
  logic [pe_cfg_pkg::GROUPS_L1-1:0] mask_l2;
  logic [pe_cfg_pkg::GROUPS_L0-1:0] mask_l1;
  logic [pe_cfg_pkg::REQ_W-1:0]     mask_l0;

  pe_group_level #(.N_GROUPS(pe_cfg_pkg::GROUPS_L0)) u_level0 (
    .req      (req),
    .grant    (grant_l0),
    .group_any(any_l0)
  );

  pe_group_level #(.N_GROUPS(pe_cfg_pkg::GROUPS_L1)) u_level1 (
    .req      (any_l0),
    .grant    (grant_l1),
    .group_any(any_l1)
  );

  pe_group_level #(.N_GROUPS(pe_cfg_pkg::GROUPS_L2)) u_level2 (
    .req      (any_l1),
    .grant    (grant_l2),
    .group_any(any_l2)
  );

  pe_group_level #(.N_GROUPS(pe_cfg_pkg::GROUPS_L3)) u_level3 (
    .req      (any_l2),
    .grant    (grant_l3),
    .group_any(any_l3)
  );

  // top down, a bit survives only if its parent group won
  always_comb begin
    for (int k = 0; k < pe_cfg_pkg::GROUPS_L1; k++) begin
      mask_l2[k] = grant_l2[k] & grant_l3[k / pe_cfg_pkg::GROUP_W];
    end
    for (int k = 0; k < pe_cfg_pkg::GROUPS_L0; k++) begin
      mask_l1[k] = grant_l1[k] & mask_l2[k / pe_cfg_pkg::GROUP_W];
    end
    for (int k = 0; k < pe_cfg_pkg::REQ_W; k++) begin
      mask_l0[k] = grant_l0[k] & mask_l1[k / pe_cfg_pkg::GROUP_W];
    end
  end

  assign grant   = mask_l0;
  assign any_set = any_l3[0];

endmodule

//--- hw/pe_index_encoder.sv
module pe_index_encoder (
  input  logic                     clk,
  input  logic                     reset,
  input  pe_types_pkg::grant_vec_t grant,
  input  logic                     any_set,
  output pe_types_pkg::pe_result_t result
);

  logic [pe_cfg_pkg::REQ_W-1:0] grant_flat;
  logic [pe_cfg_pkg::IDX_W-1:0] idx_next;
  pe_types_pkg::pe_result_t     result_q;

  assign grant_flat = grant;

  // grant is one-hot, so OR-ing the positions is enough
  always_comb begin
    idx_next = '0;
    for (int i = 0; i < pe_cfg_pkg::REQ_W; i++) begin
      if (grant_flat[i]) begin
        idx_next = idx_next | pe_cfg_pkg::IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= pe_types_pkg::RESULT_IDLE;
    end else begin
      result_q.valid <= any_set;
      result_q.index <= idx_next;
    end
  end

  assign result = result_q;

endmodule

//--- hw/pe_256.sv
module pe_256 (
  input  logic                     clk,
  input  logic                     reset,
  input  pe_types_pkg::req_vec_t   request,
  output pe_types_pkg::pe_result_t result
);

  pe_types_pkg::req_vec_t   captured;
  pe_types_pkg::grant_vec_t grant;
  logic                     any_set;

  // edge 1
  pe_req_capture u_capture (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .captured(captured)
  );

  // combinational tree between the two registers
  pe_priority_tree u_tree (
    .req    (captured),
    .grant  (grant),
    .any_set(any_set)
  );

  // edge 2
  pe_index_encoder u_encoder (
    .clk    (clk),
    .reset  (reset),
    .grant  (grant),
    .any_set(any_set),
    .result (result)
  );

endmodule

//--- sim/pe_256_chk.sv
module pe_256_chk (
  input logic                     clk,
  input logic                     reset,
  input pe_types_pkg::req_vec_t   request,
  input pe_types_pkg::pe_result_t result
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [pe_cfg_pkg::REQ_W-1:0] req_d1;
  logic [pe_cfg_pkg::REQ_W-1:0] req_d2;

  // request as the result sees it two edges later, cleared like the capture stage
  always_ff @(posedge clk) begin
    if (reset) begin
      req_d1 <= '0;
      req_d2 <= '0;
    end else begin
      req_d1 <= request;
      req_d2 <= req_d1;
    end
  end

  valid_follows_request: assert property (
    @(posedge clk) disable iff (reset)
    result.valid == (req_d2 != '0)
  ) else $error("valid does not match the request two cycles earlier");

  idle_index_zero: assert property (
    @(posedge clk) disable iff (reset)
    !result.valid |-> result.index == pe_cfg_pkg::IDX_W'(0)
  ) else $error("index is nonzero while valid is low");

  index_bit_was_set: assert property (
    @(posedge clk) disable iff (reset)
    result.valid |-> req_d2[result.index]
  ) else $error("index points at a request bit that was not set");

endmodule

bind pe_256 pe_256_chk u_chk (
  .clk    (clk),
  .reset  (reset),
  .request(request),
  .result (result)
);

//--- sim/pe_256_tb.sv
module pe_256_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          HALF_PERIOD  = 2;
  localparam int          CLK_PERIOD   = 2 * HALF_PERIOD;
  localparam int          RESET_CYCLES = 2;
  localparam int          PIPE_DEPTH   = 2;
  localparam int          RUN_LIMIT    = 20000;
  localparam int          N_DENSE      = 8;
  localparam int          N_SPARSE     = 16;
  localparam logic [31:0] LFSR_SEED    = 32'hf7c;

  typedef struct packed {
    pe_types_pkg::req_vec_t   request;
    pe_types_pkg::pe_result_t expected;
  } vector_t;

  logic                     clk;
  logic                     reset;
  pe_types_pkg::req_vec_t   request;
  pe_types_pkg::pe_result_t result;

  vector_t     vectors[$];
  string       names[$];
  logic [31:0] lfsr_state;
  int          passed;
  int          errors;
  bit          timed_out;

  pe_256 UUT (
    .clk    (clk),
    .reset  (reset),
    .request(request),
    .result (result)
  );

  always #HALF_PERIOD clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], take_bit()};
    end
    return bits;
  endfunction

  function automatic pe_types_pkg::req_vec_t one_bit(input int pos);
    logic [pe_cfg_pkg::REQ_W-1:0] flat;
    flat = '0;
    flat[pos] = 1'b1;
    return flat;
  endfunction

  function automatic pe_types_pkg::pe_result_t make_result(input logic valid, input int index);
    pe_types_pkg::pe_result_t r;
    r.valid = valid;
    r.index = pe_cfg_pkg::IDX_W'(index);
    return r;
  endfunction

  // reference model, last set bit found wins
  function automatic pe_types_pkg::pe_result_t highest_set(input pe_types_pkg::req_vec_t v);
    logic [pe_cfg_pkg::REQ_W-1:0] flat;
    pe_types_pkg::pe_result_t     r;
    flat = v;
    r = make_result(1'b0, 0);
    for (int i = 0; i < pe_cfg_pkg::REQ_W; i++) begin
      if (flat[i]) begin
        r = make_result(1'b1, i);
      end
    end
    return r;
  endfunction

  function automatic pe_types_pkg::req_vec_t random_dense();
    logic [pe_cfg_pkg::REQ_W-1:0] flat;
    for (int i = 0; i < pe_cfg_pkg::REQ_W; i++) begin
      flat[i] = take_bit();
    end
    return flat;
  endfunction

  // zero to three bits at random positions
  function automatic pe_types_pkg::req_vec_t random_sparse();
    pe_types_pkg::req_vec_t v;
    int                     n_bits;
    v = '0;
    n_bits = int'(take_bits(2));
    for (int b = 0; b < n_bits; b++) begin
      v = v | one_bit(int'(take_bits(pe_cfg_pkg::IDX_W)));
    end
    return v;
  endfunction

  task automatic add_entry(input string name, input pe_types_pkg::req_vec_t req,
                           input pe_types_pkg::pe_result_t expected);
    vector_t e;
    e.request  = req;
    e.expected = expected;
    vectors.push_back(e);
    names.push_back(name);
  endtask

  task automatic build_table();
    int                     single_pos[8];
    pe_types_pkg::req_vec_t v;
    single_pos = '{0, 3, 4, 63, 64, 127, 128, 255};
    foreach (single_pos[i]) begin
      add_entry($sformatf("single_%0d", single_pos[i]), one_bit(single_pos[i]),
                make_result(1'b1, single_pos[i]));
    end
    add_entry("bits_5_200", one_bit(5) | one_bit(200), make_result(1'b1, 200));
    add_entry("bits_17_16", one_bit(17) | one_bit(16), make_result(1'b1, 17));
    // same leaf group
    add_entry("bits_62_63", one_bit(62) | one_bit(63), make_result(1'b1, 63));
    // neighbouring level 2 groups
    add_entry("bits_63_64", one_bit(63) | one_bit(64), make_result(1'b1, 64));
    add_entry("bits_0_128_255", one_bit(0) | one_bit(128) | one_bit(255),
              make_result(1'b1, 255));
    add_entry("zero_after_nonzero", '0, make_result(1'b0, 0));
    add_entry("bits_1_2_3", one_bit(1) | one_bit(2) | one_bit(3), make_result(1'b1, 3));
    add_entry("all_ones", '1, make_result(1'b1, 255));
    add_entry("zero_after_all_ones", '0, make_result(1'b0, 0));
    for (int i = 0; i < N_DENSE; i++) begin
      v = random_dense();
      add_entry($sformatf("lfsr_dense_%0d", i), v, highest_set(v));
    end
    for (int i = 0; i < N_SPARSE; i++) begin
      v = random_sparse();
      add_entry($sformatf("lfsr_sparse_%0d", i), v, highest_set(v));
    end
  endtask

  task automatic wait_falling(input int edges);
    int      seen;
    realtime deadline;
    seen = 0;
    deadline = $realtime + real'((edges + 1) * CLK_PERIOD);
    while (seen < edges && !timed_out) begin
      @(negedge clk);
      seen++;
      if ($realtime > deadline) begin
        $display("timeout: falling clock edge came later than expected");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic compare_result(input string name, input pe_types_pkg::pe_result_t expected);
    bit same;
    same = (result === expected);
    assert (same) else begin
      errors++;
      $display("ERR %s: expected valid %0b index %0d, actual valid %0b index %0d",
               name, expected.valid, expected.index, result.valid, result.index);
    end
    if (same) begin
      passed++;
      $display("ok  %s: valid %0b index %0d", name, result.valid, result.index);
    end
  endtask

  initial begin : main
    int total;
    clk        = 1'b0;
    reset      = 1'b1;
    // all lines set during reset, the capture stage has to drop them
    request    = '1;
    passed     = 0;
    errors     = 0;
    timed_out  = 1'b0;
    lfsr_state = LFSR_SEED;
    build_table();
    total = vectors.size() + 1;

    wait_falling(RESET_CYCLES);
    reset   = 1'b0;
    request = '0;
    wait_falling(1);
    if (!timed_out) begin
      compare_result("reset_idle", make_result(1'b0, 0));
    end

    // one vector per cycle, each checked two edges later
    for (int k = 0; k < vectors.size() + PIPE_DEPTH && !timed_out; k++) begin
      if (k < vectors.size()) begin
        request = vectors[k].request;
      end else begin
        request = '0;
      end
      if (k >= PIPE_DEPTH) begin
        compare_result(names[k - PIPE_DEPTH], vectors[k - PIPE_DEPTH].expected);
      end
      wait_falling(1);
    end

    $display("tests %0d, passed %0d, failed %0d", total, passed, total - passed);
    if (!timed_out && errors == 0 && passed == total) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #RUN_LIMIT;
    $display("timeout: simulation did not finish within its time limit");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- pe_256.f
hw/pe_cfg_pkg.sv
hw/pe_types_pkg.sv
hw/pe_req_capture.sv
hw/pe_group_level.sv
hw/pe_priority_tree.sv
hw/pe_index_encoder.sv
hw/pe_256.sv
sim/pe_256_chk.sv
sim/pe_256_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the pe_256 testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=pe_256_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f pe_256.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
  echo "simulation log holds no final result"
  exit 1
fi

exit 0
